/* src/mips_isa_pkg.sv */
package mips_isa_pkg;

    // raw instruction word and byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;

    // mips field widths
    typedef logic [5:0]  opcode_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;

    // all ones word stops the stepping
    localparam word_t halt_word = '1;

    // r-format instructions carry opcode zero, operation sits in funct
    localparam opcode_t opcode_special = 6'd0;

    // the two j-format opcodes
    localparam opcode_t opcode_j   = 6'd2;
    localparam opcode_t opcode_jal = 6'd3;

    // one word per fetch, no branches
    localparam pc_t pc_incr = 32'd4;

    // coarse instruction class reported with each fetch
    typedef enum logic [1:0] {
        fmt_r,
        fmt_i,
        fmt_j,
        fmt_halt
    } instr_format_e;

endpackage

/* src/imem_pkg.sv */
package imem_pkg;

    // instruction memory size in words
    localparam int imem_depth  = 256;
    localparam int imem_addr_w = $clog2(imem_depth);

    // bytes packed into one instruction word
    localparam int bytes_per_word = 4;

    // word index into the memory
    typedef logic [imem_addr_w-1:0] word_addr_t;

    // one byte of the program stream
    typedef logic [7:0] byte_data_t;

    // loading first, then run until reset
    typedef enum logic {
        st_load,
        st_run
    } loader_state_e;

endpackage

/* src/imem_read_if.sv */
`timescale 1ns/1ps

interface imem_read_if
    import mips_isa_pkg::*;
    import imem_pkg::*;
();

    // read strobe and word index from fetch
    logic       rd;
    word_addr_t addr;

    // word comes back one cycle after rd
    word_t      rdata;
    logic       rvalid;

    modport fetch (
        output rd,
        output addr,
        input  rdata,
        input  rvalid
    );

    modport memory (
        input  rd,
        input  addr,
        output rdata,
        output rvalid
    );

endinterface

/* src/program_loader.sv */
`timescale 1ns/1ps

module program_loader
    import mips_isa_pkg::*;
    import imem_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       byte_valid,
    input  byte_data_t byte_data,
    input  logic       run_start,
    output logic       wr,
    output word_addr_t waddr,
    output word_t      wdata,
    output logic       running
);

    loader_state_e state;
    logic [1:0]    byte_cnt;
    word_t         shreg;
    word_addr_t    wr_addr;
    logic          last_byte;
    logic          take_byte;

    // fourth byte of the current word
    assign last_byte = byte_cnt == 2'(bytes_per_word - 1);

    // bytes only count while loading and not on the run_start cycle
    assign take_byte = byte_valid && state == st_load && !run_start;

    assign running = state == st_run;
    assign waddr   = wr_addr;
    assign wdata   = shreg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_load;
            byte_cnt <= 2'd0;
            wr_addr  <= '0;
            wr       <= 1'b0;
        end else begin
            wr <= 1'b0;
            // next word slot once the write has gone out
            if (wr) begin
                wr_addr <= wr_addr + word_addr_t'(1);
            end
            case (state)
                st_load: begin
                    if (run_start) begin
                        // leftover bytes of a partial word are dropped
                        state    <= st_run;
                        byte_cnt <= 2'd0;
                    end else if (take_byte) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        wr       <= last_byte;
                    end
                end
                default: begin
                    // st_run stays until reset
                    state <= st_run;
                end
            endcase
        end
    end

    // little endian, first byte drifts down to bits 7:0
    always_ff @(posedge clk) begin
        if (take_byte) begin
            shreg <= {byte_data, shreg[$bits(word_t)-1:$bits(byte_data_t)]};
        end
    end

    // no memory writes once the program is running
    a_no_wr_in_run: assert property (@(posedge clk) disable iff (reset)
        state == st_run |-> !wr)
        else $error("loader wrote memory in run state");

endmodule

/* src/instruction_memory.sv */
`timescale 1ns/1ps

module instruction_memory
    import mips_isa_pkg::*;
    import imem_pkg::*;
(
    input  logic        clk,
    input  logic        wr,
    input  word_addr_t  waddr,
    input  word_t       wdata,
    imem_read_if.memory rport
);

    // text segment
    word_t mem [imem_depth];

    // empty memory at power up
    initial begin
        for (int i = 0; i < imem_depth; i++) begin
            mem[i] = '0;
        end
    end

    // write port from the loader
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, rvalid tracks rd one cycle late
    always_ff @(posedge clk) begin
        rport.rvalid <= rport.rd;
        if (rport.rd) begin
            rport.rdata <= mem[rport.addr];
        end
    end

    // loading and fetching never overlap
    a_no_wr_rd_overlap: assert property (@(posedge clk)
        !(wr && rport.rd))
        else $error("write and read strobes in the same cycle");

endmodule

/* src/fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode
    import mips_isa_pkg::*;
    import imem_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          step,
    input  logic          running,
    imem_read_if.fetch    rport,
    output logic          halted,
    output logic          out_valid,
    output pc_t           out_pc,
    output word_t         out_word,
    output instr_format_e out_format,
    output opcode_t       opcode,
    output reg_idx_t      rs,
    output reg_idx_t      rt,
    output reg_idx_t      rd,
    output imm_t          imm,
    output funct_t        funct
);

    pc_t  pc;
    // pc of the word now on rdata, second slot of the in-flight queue
    pc_t  pc_mem;
    logic issue;
    logic accept;

    // halt first, then by opcode
    function automatic instr_format_e classify(word_t w);
        opcode_t op;
        op = w[31:26];
        if (w == halt_word) begin
            return fmt_halt;
        end
        if (op == opcode_special) begin
            return fmt_r;
        end
        if (op == opcode_j || op == opcode_jal) begin
            return fmt_j;
        end
        return fmt_i;
    endfunction

    // step only counts while running and not halted
    assign issue  = step && running && !halted;
    // results behind a halt are dropped
    assign accept = rport.rvalid && !halted;

    assign rport.rd   = issue;
    assign rport.addr = pc[imem_addr_w+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= '0;
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            // counter moves forward only
            if (issue) begin
                pc <= pc + pc_incr;
            end
            out_valid <= accept;
            if (accept && rport.rdata == halt_word) begin
                halted <= 1'b1;
            end
        end
    end

    // capture pc alongside the read
    always_ff @(posedge clk) begin
        if (issue) begin
            pc_mem <= pc;
        end
    end

    // field split and class, one cycle after rvalid
    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc     <= pc_mem;
            out_word   <= rport.rdata;
            out_format <= classify(rport.rdata);
            opcode     <= rport.rdata[31:26];
            rs         <= rport.rdata[25:21];
            rt         <= rport.rdata[20:16];
            rd         <= rport.rdata[15:11];
            imm        <= rport.rdata[15:0];
            funct      <= rport.rdata[5:0];
        end
    end

    // memory answers exactly one cycle after a read strobe
    a_rvalid_after_rd: assert property (@(posedge clk) disable iff (reset)
        rport.rvalid |-> $past(rport.rd))
        else $error("rvalid without a read one cycle earlier");

endmodule

/* src/imem_fetch_top.sv */
`timescale 1ns/1ps

module imem_fetch_top
    import mips_isa_pkg::*;
    import imem_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          byte_valid,
    input  byte_data_t    byte_data,
    input  logic          run_start,
    input  logic          step,
    output logic          running,
    output logic          halted,
    output logic          out_valid,
    output pc_t           out_pc,
    output word_t         out_word,
    output instr_format_e out_format,
    output opcode_t       opcode,
    output reg_idx_t      rs,
    output reg_idx_t      rt,
    output reg_idx_t      rd,
    output imm_t          imm,
    output funct_t        funct
);

    // loader to memory write side
    logic       wr;
    word_addr_t waddr;
    word_t      wdata;

    // fetch to memory read side
    imem_read_if rbus ();

    program_loader u_loader (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .run_start  (run_start),
        .wr         (wr),
        .waddr      (waddr),
        .wdata      (wdata),
        .running    (running)
    );

    instruction_memory u_imem (
        .clk   (clk),
        .wr    (wr),
        .waddr (waddr),
        .wdata (wdata),
        .rport (rbus.memory)
    );

    fetch_decode u_fetch (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .running    (running),
        .rport      (rbus.fetch),
        .halted     (halted),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_word   (out_word),
        .out_format (out_format),
        .opcode     (opcode),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .imm        (imm),
        .funct      (funct)
    );

endmodule

/* test/tb_imem_fetch_top.sv */
`timescale 1ns/1ps

module tb_imem_fetch_top
    import mips_isa_pkg::*;
    import imem_pkg::*;
();

    localparam int prog_words = 24;
    localparam int prog_len   = prog_words + 1;
    // about 100 bytes and 100 steps at 4 cycles each with margin
    localparam int max_cycles = 2000;

    logic          clk;
    logic          reset;
    logic          byte_valid;
    byte_data_t    byte_data;
    logic          run_start;
    logic          step;
    logic          running;
    logic          halted;
    logic          out_valid;
    pc_t           out_pc;
    word_t         out_word;
    instr_format_e out_format;
    opcode_t       opcode;
    reg_idx_t      rs;
    reg_idx_t      rt;
    reg_idx_t      rd;
    imm_t          imm;
    funct_t        funct;

    // reference model state
    word_t       prog [prog_len];
    logic        m_running;
    logic        m_halted;
    logic        st1_v;
    logic        out_v;
    int          pc_idx;
    int          st1_idx;
    int          out_idx;
    int          n_out;
    int          cycles;
    logic [31:0] lcg_state;

    imem_fetch_top dut (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .run_start  (run_start),
        .step       (step),
        .running    (running),
        .halted     (halted),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_word   (out_word),
        .out_format (out_format),
        .opcode     (opcode),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .imm        (imm),
        .funct      (funct)
    );

    initial begin
        clk = 1'b0;
    end

    // 40 ns period
    always #20 clk = ~clk;

    // returns the upper half of the lcg state
    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]);
    endfunction

    // format rules straight from the isa description
    function automatic instr_format_e expected_format(word_t w);
        if (w == halt_word) begin
            return fmt_halt;
        end
        case (w[31:26])
            opcode_special:       return fmt_r;
            opcode_j, opcode_jal: return fmt_j;
            default:              return fmt_i;
        endcase
    endfunction

    task automatic report_mismatch(string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_pc(string what, pc_t got, pc_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_format(string what, instr_format_e got, instr_format_e exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %s, expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_field(string what, opcode_t got, opcode_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_reg(string what, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_imm(string what, imm_t got, imm_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b, expected %b", what, got, exp));
        end
    endtask

    // one byte and 0 to 3 idle cycles
    // random steps here come before running
    task automatic send_byte(byte_data_t b);
        int gap;
        gap = next_rand() % 4;
        @(posedge clk);
        byte_valid <= 1'b1;
        byte_data  <= b;
        step       <= (next_rand() % 2) == 1;
        repeat (gap) begin
            @(posedge clk);
            byte_valid <= 1'b0;
            step       <= (next_rand() % 2) == 1;
        end
    endtask

    // model compares the cycle that just ended and then advances
    always @(posedge clk) begin
        logic  issue;
        logic  accept;
        word_t w;
        if (reset) begin
            m_running <= 1'b0;
            m_halted  <= 1'b0;
            st1_v     <= 1'b0;
            out_v     <= 1'b0;
            pc_idx    <= 0;
            n_out     <= 0;
        end else begin
            check_flag("running", running, m_running);
            check_flag("halted", halted, m_halted);
            check_flag("out_valid", out_valid, out_v);
            if (out_v) begin
                w = prog[out_idx];
                check_word("out_word", out_word, w);
                check_pc("out_pc", out_pc, pc_t'(out_idx * 4));
                check_format("out_format", out_format, expected_format(w));
                check_field("opcode", opcode, w[31:26]);
                check_reg("rs", rs, w[25:21]);
                check_reg("rt", rt, w[20:16]);
                check_reg("rd", rd, w[15:11]);
                check_imm("imm", imm, w[15:0]);
                check_field("funct", funct, w[5:0]);
                n_out <= n_out + 1;
            end
            issue  = step && m_running && !m_halted;
            // anything behind the halt dies here
            accept = st1_v && !m_halted;
            m_running <= m_running || run_start;
            st1_v     <= issue;
            st1_idx   <= pc_idx;
            if (issue) begin
                pc_idx <= pc_idx + 1;
            end
            out_v   <= accept;
            out_idx <= st1_idx;
            if (accept && prog[st1_idx] == halt_word) begin
                m_halted <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles >= max_cycles) begin
                $display("timeout, run did not finish within %0d cycles", max_cycles);
                $display("RESULT: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        word_t w;
        reset      <= 1'b1;
        byte_valid <= 1'b0;
        byte_data  <= '0;
        run_start  <= 1'b0;
        step       <= 1'b0;
        lcg_state = 32'd82;
        // class picked first so r and j formats show up often
        for (int i = 0; i < prog_words; i++) begin
            w[31:16] = 16'(next_rand());
            w[15:0]  = 16'(next_rand());
            case (next_rand() % 4)
                0: w[31:26] = opcode_special;
                1: w[31:26] = (next_rand() % 2 == 0) ? opcode_j : opcode_jal;
                default: ;
            endcase
            if (w == halt_word) begin
                w[0] = 1'b0;
            end
            prog[i] = w;
        end
        prog[prog_words] = halt_word;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // little endian byte stream
        for (int i = 0; i < prog_len; i++) begin
            for (int b = 0; b < 4; b++) begin
                send_byte(prog[i][8*b +: 8]);
            end
        end
        // two bytes of an unfinished word that run_start drops
        send_byte(8'(next_rand()));
        send_byte(8'(next_rand()));
        @(posedge clk);
        byte_valid <= 1'b0;
        step       <= 1'b0;
        @(posedge clk);
        run_start <= 1'b1;
        @(posedge clk);
        run_start <= 1'b0;
        // adjacent steps keep two fetches in flight
        repeat (6) begin
            @(posedge clk);
            step <= 1'b1;
        end
        while (!m_halted) begin
            @(posedge clk);
            // steps stay high near the halt so a fetch trails it
            step <= pc_idx >= prog_words || next_rand() % 3 != 0;
        end
        // late steps after the halt
        repeat (12) begin
            @(posedge clk);
            step <= (next_rand() % 2) == 1;
        end
        @(posedge clk);
        step <= 1'b0;
        repeat (4) @(posedge clk);
        if (n_out != prog_len) begin
            $display("saw %0d outputs but the program has %0d words", n_out, prog_len);
            $display("RESULT: FAIL");
            $fatal(1, "output count");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* sources.f */
src/mips_isa_pkg.sv
src/imem_pkg.sv
src/imem_read_if.sv
src/program_loader.sv
src/instruction_memory.sv
src/fetch_decode.sv
src/imem_fetch_top.sv
test/tb_imem_fetch_top.sv

/* Makefile */
SIM      = verilator
TOP      = tb_imem_fetch_top
FILELIST = sources.f
OBJ_DIR  = obj_dir
SIMFLAGS = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIMFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
